// File: Bender.yml
package:
  name: cache2way

sources:
  - include_dirs:
      - design
    files:
      - design/cache_pkg.sv
      - design/tag_array.sv
      - design/data_array.sv
      - design/cache_ctrl.sv
      - design/cache_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/tb_mem_model.sv
      - tests/tb_cache.sv

// File: cache2way.f
+incdir+design
design/cache_pkg.sv
design/tag_array.sv
design/data_array.sv
design/cache_ctrl.sv
design/cache_top.sv
tests/tb_mem_model.sv
tests/tb_cache.sv

// File: design/cache_ctrl.sv
module cache_ctrl (
    input  logic  clk,
    input  logic  proc_reset,
    input  logic  proc_read,
    input  logic  proc_write,
    input  logic  hit,
    input  logic  victim_dirty,
    input  logic  mem_ready,
    output logic  proc_stall,
    output logic  mem_read,
    output logic  mem_write,
    output logic  write_en,
    output logic  fill_en,
    output logic  touch_en
);
    import cache_pkg::*;

    ctrl_state_t  state;
    ctrl_state_t  state_nxt;

    logic         req;
    logic         cmp_hit;

    assign req     = proc_read | proc_write;
    assign cmp_hit = (state == ST_COMPARE) & hit;

    // a hit in compare is the only way a request completes
    assign proc_stall = req & ~cmp_hit;

    assign write_en = cmp_hit & proc_write;
    assign touch_en = cmp_hit & req;
    assign fill_en  = (state == ST_REFILL) & mem_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_COMPARE: begin
                if (req && !hit) begin
                    // dirty victim has to reach memory first
                    state_nxt = victim_dirty ? ST_WRITE_BACK : ST_REFILL;
                end
            end
            ST_WRITE_BACK: begin
                if (mem_ready) begin
                    state_nxt = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (mem_ready) begin
                    state_nxt = ST_COMPARE;  // request hits next cycle
                end
            end
            default: begin
                state_nxt = ST_COMPARE;
            end
        endcase
    end

    // strobes follow the next state, drop on the mem_ready edge
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state     <= ST_COMPARE;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            state     <= state_nxt;
            mem_read  <= (state_nxt == ST_REFILL);
            mem_write <= (state_nxt == ST_WRITE_BACK);
        end
    end

endmodule

// File: design/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// basic geometry
`define CACHE_WORD_W        32
`define CACHE_LINE_WORDS    4
`define CACHE_SETS          4
// replacement is a single bit, so two ways only
`define CACHE_WAYS          2
`define CACHE_PROC_ADDR_W   30

// derived widths
`define CACHE_LINE_W        (`CACHE_WORD_W * `CACHE_LINE_WORDS)
`define CACHE_OFF_W         ($clog2(`CACHE_LINE_WORDS))
`define CACHE_IDX_W         ($clog2(`CACHE_SETS))
`define CACHE_TAG_W         (`CACHE_PROC_ADDR_W - `CACHE_IDX_W - `CACHE_OFF_W)
`define CACHE_LINE_ADDR_W   (`CACHE_PROC_ADDR_W - `CACHE_OFF_W)

`endif

// File: design/cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

    typedef logic [`CACHE_WORD_W-1:0]             word_t;
    typedef logic [`CACHE_LINE_W-1:0]             line_t;
    typedef logic [`CACHE_PROC_ADDR_W-1:0]        proc_addr_t;
    typedef logic [`CACHE_OFF_W-1:0]              word_off_t;
    typedef logic [`CACHE_IDX_W-1:0]              set_idx_t;
    typedef logic [`CACHE_TAG_W-1:0]              tag_t;
    typedef logic [`CACHE_LINE_ADDR_W-1:0]        line_addr_t;  // {tag, set}
    typedef logic [$clog2(`CACHE_WAYS)-1:0]       way_t;

    typedef enum logic [1:0] {
        ST_COMPARE,
        ST_WRITE_BACK,
        ST_REFILL
    } ctrl_state_t;

    // address fields, tag | set | word offset
    function automatic tag_t addr_tag(input proc_addr_t addr);
        return addr[`CACHE_PROC_ADDR_W-1 -: `CACHE_TAG_W];
    endfunction

    function automatic set_idx_t addr_set(input proc_addr_t addr);
        return addr[`CACHE_OFF_W +: `CACHE_IDX_W];
    endfunction

    function automatic word_off_t addr_off(input proc_addr_t addr);
        return addr[`CACHE_OFF_W-1:0];
    endfunction

endpackage

// File: design/cache_top.sv
module cache_top (
    input  logic                   clk,
    input  logic                   proc_reset,
    input  logic                   proc_read,
    input  logic                   proc_write,
    input  cache_pkg::proc_addr_t  proc_addr,
    input  cache_pkg::word_t       proc_wdata,
    output cache_pkg::word_t       proc_rdata,
    output logic                   proc_stall,
    output logic                   mem_read,
    output logic                   mem_write,
    output cache_pkg::line_addr_t  mem_addr,
    output cache_pkg::line_t       mem_wdata,
    input  cache_pkg::line_t       mem_rdata,
    input  logic                   mem_ready
);
    import cache_pkg::*;

    // tag array to controller
    logic  hit;
    logic  victim_dirty;
    way_t  hit_way;
    way_t  victim_way;

    // controller to both arrays
    logic  write_en;
    logic  fill_en;
    logic  touch_en;

    cache_ctrl i_cache_ctrl (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_read    (proc_read),
        .proc_write   (proc_write),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .mem_ready    (mem_ready),
        .proc_stall   (proc_stall),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .write_en     (write_en),
        .fill_en      (fill_en),
        .touch_en     (touch_en)
    );

    tag_array i_tag_array (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_addr    (proc_addr),
        .write_en     (write_en),
        .fill_en      (fill_en),
        .touch_en     (touch_en),
        .mem_write    (mem_write),  // picks victim address
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .mem_addr     (mem_addr)
    );

    data_array i_data_array (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_addr    (proc_addr),
        .proc_read    (proc_read),
        .proc_wdata   (proc_wdata),
        .write_en     (write_en),
        .fill_en      (fill_en),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .mem_rdata    (mem_rdata),
        .proc_rdata   (proc_rdata),
        .mem_wdata    (mem_wdata)
    );

endmodule

// File: design/data_array.sv
`include "cache_params.svh"

module data_array (
    input  logic                   clk,
    input  logic                   proc_reset,
    input  cache_pkg::proc_addr_t  proc_addr,
    input  logic                   proc_read,
    input  cache_pkg::word_t       proc_wdata,
    input  logic                   write_en,
    input  logic                   fill_en,
    input  cache_pkg::way_t        hit_way,
    input  cache_pkg::way_t        victim_way,
    input  cache_pkg::line_t       mem_rdata,
    output cache_pkg::word_t       proc_rdata,
    output cache_pkg::line_t       mem_wdata
);
    import cache_pkg::*;

    line_t      lines [`CACHE_SETS][`CACHE_WAYS];

    set_idx_t   set_idx;
    word_off_t  word_off;
    line_t      hit_line;
    line_t      merged_line;

    assign set_idx  = addr_set(proc_addr);
    assign word_off = addr_off(proc_addr);
    assign hit_line = lines[set_idx][hit_way];

    // victim line goes out for write-back
    assign mem_wdata = lines[set_idx][victim_way];

    assign proc_rdata = proc_read ? hit_line[word_off*`CACHE_WORD_W +: `CACHE_WORD_W]
                                  : '0;

    // one word replaced, rest of the line kept
    always_comb begin
        merged_line = hit_line;
        merged_line[word_off*`CACHE_WORD_W +: `CACHE_WORD_W] = proc_wdata;
    end

    always_ff @(posedge clk) begin
        if (!proc_reset) begin  // no stores while in reset
            if (fill_en) begin
                lines[set_idx][victim_way] <= mem_rdata;
            end else if (write_en) begin
                lines[set_idx][hit_way] <= merged_line;
            end
        end
    end

endmodule

// File: design/tag_array.sv
`include "cache_params.svh"

module tag_array (
    input  logic                   clk,
    input  logic                   proc_reset,
    input  cache_pkg::proc_addr_t  proc_addr,
    input  logic                   write_en,
    input  logic                   fill_en,
    input  logic                   touch_en,
    input  logic                   mem_write,
    output logic                   hit,
    output cache_pkg::way_t        hit_way,
    output cache_pkg::way_t        victim_way,
    output logic                   victim_dirty,
    output cache_pkg::line_addr_t  mem_addr
);
    import cache_pkg::*;

    tag_t                    tags  [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]  valid [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0]  dirty [`CACHE_SETS];
    way_t                    mru   [`CACHE_SETS];  // most recently used way

    set_idx_t                set_idx;
    tag_t                    req_tag;
    logic [`CACHE_WAYS-1:0]  way_hit;

    assign set_idx = addr_set(proc_addr);
    assign req_tag = addr_tag(proc_addr);

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hit[w] = valid[set_idx][w] && (tags[set_idx][w] == req_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_t'(way_hit[1]);  // ways never both hit

    // invalid way first, else the one not used last
    always_comb begin
        if (!valid[set_idx][0]) begin
            victim_way = way_t'(0);
        end else if (!valid[set_idx][1]) begin
            victim_way = way_t'(1);
        end else begin
            victim_way = ~mru[set_idx];
        end
    end

    assign victim_dirty = dirty[set_idx][victim_way];

    // victim line address while writing back
    assign mem_addr = mem_write ? {tags[set_idx][victim_way], set_idx}
                                : {req_tag, set_idx};

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
                mru[s]   <= '0;
            end
        end else begin
            if (fill_en) begin
                valid[set_idx][victim_way] <= 1'b1;
                dirty[set_idx][victim_way] <= 1'b0;  // fresh from memory
                mru[set_idx]               <= victim_way;
            end
            if (write_en) begin
                dirty[set_idx][hit_way] <= 1'b1;
            end
            if (touch_en) begin
                mru[set_idx] <= hit_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[set_idx][victim_way] <= req_tag;
        end
    end

endmodule

// File: tests/tb_cache.sv
`include "cache_params.svh"

module tb_cache;
    import cache_pkg::*;

    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 8;
    localparam int MEM_LINES     = 64;
    localparam int DELAY_MAX     = 6;
    localparam int RAND_OPS      = 400;
    localparam int DIRECTED_OPS  = 16;
    // write-back plus refill with their delays and handshake cycles
    localparam int OP_CYCLES_MAX = 2 * (DELAY_MAX + 3) + 2;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + (DIRECTED_OPS + RAND_OPS) * (OP_CYCLES_MAX + 1) + 20;

    logic        clk;
    logic        proc_reset;
    logic        proc_read;
    logic        proc_write;
    proc_addr_t  proc_addr;
    word_t       proc_wdata;
    word_t       proc_rdata;
    logic        proc_stall;
    logic        mem_read;
    logic        mem_write;
    line_addr_t  mem_addr;
    line_t       mem_wdata;
    line_t       mem_rdata;
    logic        mem_ready;

    word_t       shadow  [MEM_LINES * `CACHE_LINE_WORDS];
    logic        written [MEM_LINES];           // line written since its last fill
    logic [`CACHE_LINE_ADDR_W:0] mem_log [$];   // {is_write, line address}
    int          mem_busy_cycles;
    int          fail_count;
    logic [31:0] rand_state;

    cache_top i_cache_top (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    tb_mem_model #(.LINES(MEM_LINES), .DELAY_MAX(DELAY_MAX)) i_mem (
        .clk        (clk),
        .proc_reset (proc_reset),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t init_pattern(input int unsigned word_addr);
        return 32'h0a5c_0000 ^ {2'b10, word_addr[29:0]};
    endfunction

    function automatic word_t expected_word(input proc_addr_t addr);
        return shadow[addr];
    endfunction

    function automatic line_t shadow_line(input line_addr_t line);
        line_t l;
        for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
            l[w*`CACHE_WORD_W +: `CACHE_WORD_W] = shadow[line * `CACHE_LINE_WORDS + w];
        end
        return l;
    endfunction

    function automatic line_addr_t line_of(input proc_addr_t addr);
        return line_addr_t'(addr / `CACHE_LINE_WORDS);
    endfunction

    task automatic check_value(input logic [`CACHE_LINE_W-1:0] got,
                               input logic [`CACHE_LINE_W-1:0] exp, input string what);
        if (got !== exp) begin
            fail_count++;
            $display("** Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic protocol_failure(input string msg);
        fail_count++;
        $display("%s (at time %0t)", msg, $time);
        $display("test failed");
        $fatal(1);
    endtask

    // request held until the first cycle with proc_stall low
    task automatic do_access(input logic is_write, input proc_addr_t addr,
                             input word_t wdata, output int stall_cycles);
        proc_read    = ~is_write;
        proc_write   = is_write;
        proc_addr    = addr;
        proc_wdata   = wdata;
        stall_cycles = 0;
        @(negedge clk);
        while (proc_stall) begin
            stall_cycles++;
            if (stall_cycles > OP_CYCLES_MAX) begin
                protocol_failure($sformatf("request to address %0h never completed", addr));
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
    endtask

    task automatic hit_access(input logic is_write, input proc_addr_t addr, input word_t wdata);
        int stalls;
        int busy_before;
        busy_before = mem_busy_cycles;
        do_access(is_write, addr, wdata, stalls);
        check_value(stalls, 0, "stall cycles on a hit");
        check_value(mem_busy_cycles - busy_before, 0, "memory strobe cycles on a hit");
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $fatal(1);
    end

    // outputs sampled at mid-cycle
    always @(negedge clk) begin
        if (proc_reset) begin
            check_value(mem_read, 1'b0, "mem_read in reset");
            check_value(mem_write, 1'b0, "mem_write in reset");
            check_value(proc_stall, 1'b0, "proc_stall in reset");
        end else begin
            if (!proc_read && !proc_write) begin
                check_value(proc_stall, 1'b0, "proc_stall without a request");
            end
            if (!proc_read) begin
                check_value(proc_rdata, '0, "proc_rdata without a read");
            end
            if (mem_read && mem_write) begin
                protocol_failure("mem_read and mem_write are high in the same cycle");
            end
            if (mem_read || mem_write) begin
                mem_busy_cycles++;
                if (mem_addr >= MEM_LINES) begin
                    protocol_failure($sformatf("memory line address %0h out of range", mem_addr));
                end
            end
            if (proc_read && !proc_stall) begin
                check_value(proc_rdata, expected_word(proc_addr), "read data");
            end
            if (proc_write && !proc_stall) begin
                shadow[proc_addr]            = proc_wdata;
                written[line_of(proc_addr)] = 1'b1;
            end
            if (mem_ready && mem_read) begin
                check_value(mem_addr, line_of(proc_addr), "refill line address");
                written[mem_addr] = 1'b0;
                mem_log.push_back({1'b0, mem_addr});
            end
            if (mem_ready && mem_write) begin
                if (!written[mem_addr]) begin
                    protocol_failure($sformatf("write-back of clean line %0h", mem_addr));
                end
                check_value(mem_wdata, shadow_line(mem_addr), "write-back data");
                mem_log.push_back({1'b1, mem_addr});
            end
        end
    end

    initial begin : stimulus
        int          stalls;
        proc_addr_t  addr;
        logic        is_wr;

        proc_reset      = 1'b1;
        proc_read       = 1'b0;
        proc_write      = 1'b0;
        proc_addr       = '0;
        proc_wdata      = '0;
        fail_count      = 0;
        mem_busy_cycles = 0;
        rand_state      = 32'ha194;
        for (int w = 0; w < MEM_LINES * `CACHE_LINE_WORDS; w++) begin
            shadow[w] = init_pattern(w);
        end
        for (int l = 0; l < MEM_LINES; l++) begin
            written[l] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        proc_reset = 1'b0;

        // idle after reset
        repeat (4) @(posedge clk);
        #1;
        check_value(mem_busy_cycles, 0, "memory strobe cycles while idle");

        // read miss on line 2
        mem_log.delete();
        do_access(1'b0, proc_addr_t'(2 * `CACHE_LINE_WORDS + 1), '0, stalls);
        check_value(stalls > 0, 1'b1, "read miss stalled");
        check_value(mem_log.size(), 1, "memory transfers for a clean miss");
        check_value(mem_log[0], {1'b0, line_addr_t'(2)}, "refill request");

        // hits on the filled line
        hit_access(1'b1, proc_addr_t'(2 * `CACHE_LINE_WORDS + 3), 32'hdead_beef);
        hit_access(1'b0, proc_addr_t'(2 * `CACHE_LINE_WORDS + 3), '0);
        hit_access(1'b0, proc_addr_t'(2 * `CACHE_LINE_WORDS + 0), '0);
        hit_access(1'b1, proc_addr_t'(2 * `CACHE_LINE_WORDS + 1), 32'h0123_4567);
        hit_access(1'b0, proc_addr_t'(2 * `CACHE_LINE_WORDS + 1), '0);

        // lines 5, 9, 13 all map to set 1
        do_access(1'b1, proc_addr_t'(5 * `CACHE_LINE_WORDS + 2), 32'h1111_aaaa, stalls);
        do_access(1'b1, proc_addr_t'(9 * `CACHE_LINE_WORDS + 0), 32'h2222_bbbb, stalls);
        mem_log.delete();
        do_access(1'b0, proc_addr_t'(13 * `CACHE_LINE_WORDS + 3), '0, stalls);
        check_value(mem_log.size(), 2, "memory transfers for a dirty eviction");
        check_value(mem_log[0], {1'b1, line_addr_t'(5)}, "write-back of the LRU line");
        check_value(mem_log[1], {1'b0, line_addr_t'(13)}, "refill after write-back");
        do_access(1'b0, proc_addr_t'(5 * `CACHE_LINE_WORDS + 2), '0, stalls);

        // a hit on line 13 leaves the clean line 5 as LRU
        hit_access(1'b1, proc_addr_t'(13 * `CACHE_LINE_WORDS + 1), 32'h3333_cccc);
        mem_log.delete();
        do_access(1'b0, proc_addr_t'(9 * `CACHE_LINE_WORDS + 0), '0, stalls);
        check_value(mem_log.size(), 1, "memory transfers after a hit moved the MRU way");
        check_value(mem_log[0], {1'b0, line_addr_t'(9)}, "refill replacing the LRU line");

        // random mix over 16 lines
        for (int i = 0; i < RAND_OPS; i++) begin
            rand_state = xorshift32(rand_state);
            addr       = proc_addr_t'(rand_state[5:0]);
            is_wr      = rand_state[8];
            rand_state = xorshift32(rand_state);
            do_access(is_wr, addr, rand_state, stalls);
        end

        repeat (2) @(posedge clk);
        if (fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1);
        end
    end

endmodule

// File: tests/tb_mem_model.sv
`include "cache_params.svh"

module tb_mem_model #(
    parameter int LINES     = 64,
    parameter int DELAY_MAX = 6
) (
    input  logic                   clk,
    input  logic                   proc_reset,
    input  logic                   mem_read,
    input  logic                   mem_write,
    input  cache_pkg::line_addr_t  mem_addr,
    input  cache_pkg::line_t       mem_wdata,
    output cache_pkg::line_t       mem_rdata,
    output logic                   mem_ready
);
    import cache_pkg::*;

    line_t        lines [LINES];
    logic [31:0]  rand_state;
    logic         busy;
    int unsigned  wait_cnt;
    int unsigned  idx;

    assign idx = int'(mem_addr) % LINES;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // pattern over the full word address
    initial begin
        int unsigned addr;
        mem_ready <= 1'b0;
        mem_rdata <= '0;
        for (int l = 0; l < LINES; l++) begin
            for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
                addr = l * `CACHE_LINE_WORDS + w;
                lines[l][w*`CACHE_WORD_W +: `CACHE_WORD_W] = 32'h0a5c_0000 ^ {2'b10, addr[29:0]};
            end
        end
    end

    always @(posedge clk) begin
        if (proc_reset) begin
            busy       <= 1'b0;
            mem_ready  <= 1'b0;
            wait_cnt   <= 0;
            rand_state <= 32'ha194;
        end else begin
            mem_ready <= 1'b0;
            if (!mem_ready) begin  // strobe drops on the ready edge
                if (busy) begin
                    if (wait_cnt == 0) begin
                        busy      <= 1'b0;
                        mem_ready <= 1'b1;
                        if (mem_write) begin
                            lines[idx] <= mem_wdata;
                        end else begin
                            mem_rdata <= lines[idx];
                        end
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end else if (mem_read || mem_write) begin
                    busy       <= 1'b1;
                    wait_cnt   <= rand_state % DELAY_MAX;  // 1 to DELAY_MAX cycles
                    rand_state <= xorshift32(rand_state);
                end
            end
        end
    end

endmodule
